/* src/ddr_phy_macros.svh */
/*
 * DDR3 PHY data path configuration
 * Widths, DQS group counts, FIFO depths and default delays shared by the
 * write and read paths of the pad wrapper model.
 */
`ifndef DDR_PHY_MACROS_SVH
`define DDR_PHY_MACROS_SVH

// Data bus organisation per DQS group
`define DDR_DQ_PER_GROUP 8
`define DDR_NUM_GROUPS 2
`define DDR_DM_PER_GROUP 1

// Half rate AFI carries four memory time slots per AFI cycle
`define DDR_NUM_SLOTS 4
`define DDR_AFI_RATE_RATIO 2

// Core-to-periphery register depth where zero bypasses the register
`define DDR_C2P_STAGES 1

// Extra delay on the full-rate read-enable ahead of the VFIFO
`define DDR_EXTRA_VFIFO_SHIFT 2

// Valid FIFO size and the initial lead of its write pointer
`define DDR_VFIFO_DEPTH 16
`define DDR_VFIFO_BASE_OFFSET 4

// Latency FIFO taps and the sequencer latency count width
`define DDR_LFIFO_DEPTH 32
`define DDR_LAT_WIDTH 5

`endif

/* src/ddr_phy_pkg.sv */
/*
 * DDR3 PHY data path types
 * Slot, group and bus types for the AFI write bundle and the read
 * valid alignment logic.
 */
`include "ddr_phy_macros.svh"

package ddr_phy_pkg;

	// One DQS group in one time slot
	typedef logic [`DDR_DQ_PER_GROUP-1:0] dq_slot_t;
	typedef logic [`DDR_DM_PER_GROUP-1:0] dm_slot_t;

	// Full AFI buses, ordered by time slot and then by DQS group
	typedef dq_slot_t [`DDR_NUM_SLOTS*`DDR_NUM_GROUPS-1:0] afi_dq_t;
	typedef dm_slot_t [`DDR_NUM_SLOTS*`DDR_NUM_GROUPS-1:0] afi_dm_t;

	// Per group enables, first half-cycle in the low group bits
	typedef logic [`DDR_AFI_RATE_RATIO*`DDR_NUM_GROUPS-1:0] afi_half_t;

	// Everything that crosses the core-to-periphery register
	typedef struct packed {
		afi_dq_t dq;
		afi_dm_t dm;
		afi_half_t wrdata_en;
		afi_half_t dqs_en;
		afi_half_t oct_ena;
	} wr_bundle_t;

	// All slots of a single write lane
	typedef dq_slot_t [`DDR_NUM_SLOTS-1:0] group_dq_t;
	typedef dm_slot_t [`DDR_NUM_SLOTS-1:0] group_dm_t;

	typedef logic [`DDR_LAT_WIDTH-1:0] lat_t;
	typedef logic [`DDR_AFI_RATE_RATIO-1:0] afi_valid_t;

endpackage

/* src/core_periph_delay.sv */
/*
 * Core-to-periphery delay line
 * Shifts any payload through a chain of resettable registers, or passes
 * it straight through when the depth is zero.
 */
module core_periph_delay #(
	parameter type payload_t = logic,
	parameter int depth = 1
) (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input payload_t d,
	output payload_t q
);

	if (depth == 0) begin : g_bypass
		assign q = d;
	end else begin : g_chain
		payload_t stage [depth];

		// Stage 0 takes the input and the last stage drives the output
		always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
			if (!reset_n_afi_clk) begin
				for (int i = 0; i < depth; i++) begin
					stage[i] <= '0;
				end
			end else begin
				stage[0] <= d;
				for (int i = 1; i < depth; i++) begin
					stage[i] <= stage[i - 1];
				end
			end
		end

		assign q = stage[depth - 1];
	end

endmodule

/* src/write_lane.sv */
/*
 * Write lane for one DQS group
 * Picks the group's data, mask and half-cycle enables out of the slot-major
 * AFI write bundle and registers them for the output pads.
 */
`include "ddr_phy_macros.svh"

module write_lane #(
	parameter int group = 0
) (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input ddr_phy_pkg::wr_bundle_t bundle,
	output ddr_phy_pkg::group_dq_t dq,
	output ddr_phy_pkg::group_dm_t dm,
	output ddr_phy_pkg::group_dq_t dq_oe,
	output logic [`DDR_AFI_RATE_RATIO-1:0] dqs_en,
	output logic [`DDR_AFI_RATE_RATIO-1:0] oct_ena
);

	import ddr_phy_pkg::*;

	localparam int slots_per_half = `DDR_NUM_SLOTS / `DDR_AFI_RATE_RATIO;

	group_dq_t dq_nxt;
	group_dm_t dm_nxt;
	group_dq_t oe_nxt;
	logic [`DDR_AFI_RATE_RATIO-1:0] dqs_en_nxt;
	logic [`DDR_AFI_RATE_RATIO-1:0] oct_ena_nxt;

	// Slot s of this group sits at s * groups + group on the AFI bus
	always_comb begin
		for (int s = 0; s < `DDR_NUM_SLOTS; s++) begin
			dq_nxt[s] = bundle.dq[s * `DDR_NUM_GROUPS + group];
			dm_nxt[s] = bundle.dm[s * `DDR_NUM_GROUPS + group];
			// Output enable is per half-cycle, so each half covers a pair of slots
			oe_nxt[s] = {`DDR_DQ_PER_GROUP{
				bundle.wrdata_en[(s / slots_per_half) * `DDR_NUM_GROUPS + group]}};
		end
		for (int h = 0; h < `DDR_AFI_RATE_RATIO; h++) begin
			dqs_en_nxt[h] = bundle.dqs_en[h * `DDR_NUM_GROUPS + group];
			oct_ena_nxt[h] = bundle.oct_ena[h * `DDR_NUM_GROUPS + group];
		end
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			dq <= '0;
			dm <= '0;
			dq_oe <= '0;
			dqs_en <= '0;
			oct_ena <= '0;
		end else begin
			dq <= dq_nxt;
			dm <= dm_nxt;
			dq_oe <= oe_nxt;
			dqs_en <= dqs_en_nxt;
			oct_ena <= oct_ena_nxt;
		end
	end

	// Data is never driven onto the bus without its strobe for that half-cycle
	for (genvar s = 0; s < `DDR_NUM_SLOTS; s++) begin : g_oe_check
		assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
			(|dq_oe[s]) |-> dqs_en[s / slots_per_half]);
	end

endmodule

/* src/read_vfifo.sv */
/*
 * Read valid FIFO for one DQS group
 * Circular bit FIFO that delays the shifted read-enable by the write
 * pointer lead, which the sequencer can grow one step at a time.
 */
`include "ddr_phy_macros.svh"

module read_vfifo (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input logic fifo_reset,
	input logic qvld,
	input logic inc_wr_ptr,
	output logic valid
);

	localparam int ptr_w = $clog2(`DDR_VFIFO_DEPTH);

	logic [`DDR_VFIFO_DEPTH-1:0] mem;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	// Distance from read to write pointer and thus the FIFO delay
	logic [ptr_w:0] lead;

	assign wr_ptr = rd_ptr + lead[ptr_w-1:0];
	assign valid = mem[rd_ptr];

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			mem <= '0;
			rd_ptr <= '0;
			lead <= (ptr_w + 1)'(`DDR_VFIFO_BASE_OFFSET);
		end else begin
			rd_ptr <= rd_ptr + 1'b1;
			// An increment moves the write side one entry further ahead
			lead <= lead + (ptr_w + 1)'(inc_wr_ptr);
			if (fifo_reset) begin
				mem <= '0;
			end else begin
				mem[wr_ptr] <= qvld;
			end
		end
	end

	// The sequencer only increments while the lead still fits in the FIFO
	assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		inc_wr_ptr |-> lead < (ptr_w + 1)'(`DDR_VFIFO_DEPTH - 1));

endmodule

/* src/read_lfifo.sv */
/*
 * Latency FIFO for one DQS group
 * Delays the half-rate read-enable by the sequencer read latency count,
 * with a latency of zero passing the enable straight through.
 */
`include "ddr_phy_macros.svh"

module read_lfifo (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input logic fifo_reset,
	input logic rdata_en,
	input ddr_phy_pkg::lat_t rd_latency,
	output logic valid
);

	logic [`DDR_LFIFO_DEPTH-2:0] shift;
	logic [`DDR_LFIFO_DEPTH-1:0] taps;

	// Tap k holds the enable from k cycles ago
	assign taps = {shift, rdata_en};
	assign valid = taps[rd_latency];

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			shift <= '0;
		end else if (fifo_reset) begin
			shift <= '0;
		end else begin
			shift <= {shift[`DDR_LFIFO_DEPTH-3:0], rdata_en};
		end
	end

endmodule

/* src/read_valid_align.sv */
/*
 * Read valid alignment
 * Runs a VFIFO and an LFIFO per DQS group and registers the AND of all
 * group valids onto the AFI read data valid.
 */
`include "ddr_phy_macros.svh"

module read_valid_align (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input logic seq_read_fifo_reset,
	input logic rdata_en,
	input logic rdata_en_full_shifted,
	input ddr_phy_pkg::lat_t seq_read_latency_counter,
	input logic [`DDR_NUM_GROUPS-1:0] seq_read_increment_vfifo_fr,
	output ddr_phy_pkg::afi_valid_t afi_rdata_valid
);

	logic [`DDR_NUM_GROUPS-1:0] vfifo_valid;
	logic [`DDR_NUM_GROUPS-1:0] lfifo_valid;
	logic [`DDR_NUM_GROUPS-1:0] group_valid;

	for (genvar g = 0; g < `DDR_NUM_GROUPS; g++) begin : g_group
		read_vfifo read_vfifo_i (
			.pll_afi_clk(pll_afi_clk),
			.reset_n_afi_clk(reset_n_afi_clk),
			.fifo_reset(seq_read_fifo_reset),
			.qvld(rdata_en_full_shifted),
			.inc_wr_ptr(seq_read_increment_vfifo_fr[g]),
			.valid(vfifo_valid[g])
		);

		read_lfifo read_lfifo_i (
			.pll_afi_clk(pll_afi_clk),
			.reset_n_afi_clk(reset_n_afi_clk),
			.fifo_reset(seq_read_fifo_reset),
			.rdata_en(rdata_en),
			.rd_latency(seq_read_latency_counter),
			.valid(lfifo_valid[g])
		);

		// A group only counts when both FIFOs agree on the same cycle
		assign group_valid[g] = vfifo_valid[g] & lfifo_valid[g];
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			afi_rdata_valid <= '0;
		end else begin
			afi_rdata_valid <= {`DDR_AFI_RATE_RATIO{&group_valid}};
		end
	end

endmodule

/* src/ddr_phy_io_top.sv */
/*
 * DDR3 PHY I/O data path
 * Core-to-periphery register, per group write lanes, the extra VFIFO
 * shift and the read valid alignment, all on the AFI clock.
 */
`include "ddr_phy_macros.svh"

module ddr_phy_io_top (
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input ddr_phy_pkg::afi_dq_t phy_ddio_dq,
	input ddr_phy_pkg::afi_dm_t phy_ddio_wrdata_mask,
	input ddr_phy_pkg::afi_half_t phy_ddio_wrdata_en,
	input ddr_phy_pkg::afi_half_t phy_ddio_dqs_en,
	input ddr_phy_pkg::afi_half_t phy_ddio_oct_ena,
	input ddr_phy_pkg::afi_valid_t afi_rdata_en,
	input ddr_phy_pkg::afi_valid_t afi_rdata_en_full,
	input ddr_phy_pkg::lat_t seq_read_latency_counter,
	input logic [`DDR_NUM_GROUPS-1:0] seq_read_increment_vfifo_fr,
	input logic seq_read_fifo_reset,
	output ddr_phy_pkg::group_dq_t lane_dq [`DDR_NUM_GROUPS],
	output ddr_phy_pkg::group_dm_t lane_dm [`DDR_NUM_GROUPS],
	output ddr_phy_pkg::group_dq_t lane_dq_oe [`DDR_NUM_GROUPS],
	output logic [`DDR_AFI_RATE_RATIO-1:0] lane_dqs_en [`DDR_NUM_GROUPS],
	output logic [`DDR_AFI_RATE_RATIO-1:0] lane_oct_ena [`DDR_NUM_GROUPS],
	output ddr_phy_pkg::afi_valid_t afi_rdata_valid
);

	import ddr_phy_pkg::*;

	wr_bundle_t wr_bundle;
	wr_bundle_t wr_bundle_c2p;
	logic rdata_en_full_shifted;

	assign wr_bundle.dq = phy_ddio_dq;
	assign wr_bundle.dm = phy_ddio_wrdata_mask;
	assign wr_bundle.wrdata_en = phy_ddio_wrdata_en;
	assign wr_bundle.dqs_en = phy_ddio_dqs_en;
	assign wr_bundle.oct_ena = phy_ddio_oct_ena;

	// Optional register between the core and the I/O periphery
	core_periph_delay #(
		.payload_t(wr_bundle_t),
		.depth(`DDR_C2P_STAGES)
	) c2p_delay_i (
		.pll_afi_clk(pll_afi_clk),
		.reset_n_afi_clk(reset_n_afi_clk),
		.d(wr_bundle),
		.q(wr_bundle_c2p)
	);

	for (genvar g = 0; g < `DDR_NUM_GROUPS; g++) begin : g_lane
		write_lane #(
			.group(g)
		) write_lane_i (
			.pll_afi_clk(pll_afi_clk),
			.reset_n_afi_clk(reset_n_afi_clk),
			.bundle(wr_bundle_c2p),
			.dq(lane_dq[g]),
			.dm(lane_dm[g]),
			.dq_oe(lane_dq_oe[g]),
			.dqs_en(lane_dqs_en[g]),
			.oct_ena(lane_oct_ena[g])
		);
	end

	// Only the first full-rate enable bit feeds the VFIFOs
	core_periph_delay #(
		.payload_t(logic),
		.depth(`DDR_EXTRA_VFIFO_SHIFT)
	) extra_shift_i (
		.pll_afi_clk(pll_afi_clk),
		.reset_n_afi_clk(reset_n_afi_clk),
		.d(afi_rdata_en_full[0]),
		.q(rdata_en_full_shifted)
	);

	read_valid_align read_valid_align_i (
		.pll_afi_clk(pll_afi_clk),
		.reset_n_afi_clk(reset_n_afi_clk),
		.seq_read_fifo_reset(seq_read_fifo_reset),
		.rdata_en(afi_rdata_en[0]),
		.rdata_en_full_shifted(rdata_en_full_shifted),
		.seq_read_latency_counter(seq_read_latency_counter),
		.seq_read_increment_vfifo_fr(seq_read_increment_vfifo_fr),
		.afi_rdata_valid(afi_rdata_valid)
	);

endmodule

/* sim/tb_ddr_phy_io.sv */
/*
 * Testbench for the DDR3 PHY I/O data path
 * Drives seeded random write and read traffic and checks every write lane
 * and the AFI read valid against a cycle-indexed reference model.
 */
`include "ddr_phy_macros.svh"

module tb_ddr_phy_io;

	timeunit 1ns;
	timeprecision 1ps;

	import ddr_phy_pkg::*;

	localparam int groups = `DDR_NUM_GROUPS;
	localparam int slots = `DDR_NUM_SLOTS;
	localparam int rate = `DDR_AFI_RATE_RATIO;
	// About 1700 cycles of stimulus plus margin
	localparam int max_cycles = 3000;
	localparam int hist_len = max_cycles + 8;

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	afi_dq_t phy_ddio_dq;
	afi_dm_t phy_ddio_wrdata_mask;
	afi_half_t phy_ddio_wrdata_en;
	afi_half_t phy_ddio_dqs_en;
	afi_half_t phy_ddio_oct_ena;
	afi_valid_t afi_rdata_en;
	afi_valid_t afi_rdata_en_full;
	lat_t seq_read_latency_counter;
	logic [groups-1:0] seq_read_increment_vfifo_fr;
	logic seq_read_fifo_reset;
	group_dq_t lane_dq [groups];
	group_dm_t lane_dm [groups];
	group_dq_t lane_dq_oe [groups];
	logic [rate-1:0] lane_dqs_en [groups];
	logic [rate-1:0] lane_oct_ena [groups];
	afi_valid_t afi_rdata_valid;

	integer seed;
	int cyc;
	int write_errors;
	int read_errors;
	int other_errors;
	int valid_seen;
	int killed;
	int mark;
	lat_t lat;
	int lead [groups];

	// Inputs recorded by the cycle in which they were driven
	afi_dq_t dq_h [hist_len];
	afi_dm_t dm_h [hist_len];
	afi_half_t wen_h [hist_len];
	afi_half_t dqs_h [hist_len];
	afi_half_t oct_h [hist_len];
	logic en_h [hist_len];
	logic full_h [hist_len];
	logic frst_h [hist_len];

	ddr_phy_io_top ddr_phy_io_top_i (
		.pll_afi_clk(pll_afi_clk),
		.reset_n_afi_clk(reset_n_afi_clk),
		.phy_ddio_dq(phy_ddio_dq),
		.phy_ddio_wrdata_mask(phy_ddio_wrdata_mask),
		.phy_ddio_wrdata_en(phy_ddio_wrdata_en),
		.phy_ddio_dqs_en(phy_ddio_dqs_en),
		.phy_ddio_oct_ena(phy_ddio_oct_ena),
		.afi_rdata_en(afi_rdata_en),
		.afi_rdata_en_full(afi_rdata_en_full),
		.seq_read_latency_counter(seq_read_latency_counter),
		.seq_read_increment_vfifo_fr(seq_read_increment_vfifo_fr),
		.seq_read_fifo_reset(seq_read_fifo_reset),
		.lane_dq(lane_dq),
		.lane_dm(lane_dm),
		.lane_dq_oe(lane_dq_oe),
		.lane_dqs_en(lane_dqs_en),
		.lane_oct_ena(lane_oct_ena),
		.afi_rdata_valid(afi_rdata_valid)
	);

	initial begin
		pll_afi_clk = 1'b0;
		forever #50 pll_afi_clk = ~pll_afi_clk;
	end

	function automatic logic en_at(int n);
		if (n < 0) begin
			return 1'b0;
		end
		return en_h[n];
	endfunction

	function automatic logic full_at(int n);
		if (n < 0) begin
			return 1'b0;
		end
		return full_h[n];
	endfunction

	// True when a FIFO reset was sampled in any cycle from first to last
	function automatic logic reset_between(int first, int last);
		for (int r = first; r <= last; r++) begin
			if (r >= 0 && frst_h[r]) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// Valid registered at cycle k where a FIFO reset in flight kills the entry
	function automatic logic expected_valid(int k, logic with_resets);
		logic result;
		int src;
		if (k < 0) begin
			return 1'b0;
		end
		result = 1'b1;
		for (int g = 0; g < groups; g++) begin
			src = k - lead[g];
			result = result & full_at(src - 2);
			if (with_resets) begin
				result = result & !reset_between(src, k - 1);
			end
		end
		src = k - int'(lat);
		result = result & en_at(src);
		if (with_resets) begin
			result = result & !reset_between(src, k - 1);
		end
		return result;
	endfunction

	task automatic check_write();
		int idx;
		int half;
		afi_dq_t dq_src;
		afi_dm_t dm_src;
		afi_half_t wen_src;
		afi_half_t dqs_src;
		afi_half_t oct_src;
		group_dq_t exp_oe;
		idx = cyc - 2;
		dq_src = (idx >= 0) ? dq_h[idx] : '0;
		dm_src = (idx >= 0) ? dm_h[idx] : '0;
		wen_src = (idx >= 0) ? wen_h[idx] : '0;
		dqs_src = (idx >= 0) ? dqs_h[idx] : '0;
		oct_src = (idx >= 0) ? oct_h[idx] : '0;
		for (int g = 0; g < groups; g++) begin
			for (int s = 0; s < slots; s++) begin
				half = (s < slots / 2) ? 0 : 1;
				exp_oe[s] = wen_src[half * groups + g] ? '1 : '0;
				if (lane_dq[g][s] !== dq_src[s * groups + g]) begin
					write_errors++;
					$display("[ERROR] t=%0t lane_dq[%0d][%0d] expected %h actual %h",
						$time, g, s, dq_src[s * groups + g], lane_dq[g][s]);
				end
				if (lane_dm[g][s] !== dm_src[s * groups + g]) begin
					write_errors++;
					$display("[ERROR] t=%0t lane_dm[%0d][%0d] expected %h actual %h",
						$time, g, s, dm_src[s * groups + g], lane_dm[g][s]);
				end
			end
			if (lane_dq_oe[g] !== exp_oe) begin
				write_errors++;
				$display("[ERROR] t=%0t lane_dq_oe[%0d] expected %h actual %h",
					$time, g, exp_oe, lane_dq_oe[g]);
			end
			for (int h = 0; h < rate; h++) begin
				if (lane_dqs_en[g][h] !== dqs_src[h * groups + g]) begin
					write_errors++;
					$display("[ERROR] t=%0t lane_dqs_en[%0d][%0d] expected %b actual %b",
						$time, g, h, dqs_src[h * groups + g], lane_dqs_en[g][h]);
				end
				if (lane_oct_ena[g][h] !== oct_src[h * groups + g]) begin
					write_errors++;
					$display("[ERROR] t=%0t lane_oct_ena[%0d][%0d] expected %b actual %b",
						$time, g, h, oct_src[h * groups + g], lane_oct_ena[g][h]);
				end
			end
		end
	endtask

	task automatic check_read();
		afi_valid_t exp;
		exp = expected_valid(cyc - 1, 1'b1) ? '1 : '0;
		if (afi_rdata_valid !== exp) begin
			read_errors++;
			$display("[ERROR] t=%0t afi_rdata_valid expected %b actual %b",
				$time, exp, afi_rdata_valid);
		end
		if (afi_rdata_valid[0] === 1'b1) begin
			valid_seen++;
		end
		// A burst that lines up but meets a FIFO reset on the way
		if (exp[0] == 1'b0 && expected_valid(cyc - 1, 1'b0)) begin
			killed++;
		end
	endtask

	task automatic check_reset_state();
		for (int g = 0; g < groups; g++) begin
			if (lane_dq_oe[g] !== '0) begin
				other_errors++;
				$display("[ERROR] t=%0t lane_dq_oe[%0d] expected 0 actual %h",
					$time, g, lane_dq_oe[g]);
			end
			if (lane_dqs_en[g] !== '0) begin
				other_errors++;
				$display("[ERROR] t=%0t lane_dqs_en[%0d] expected 00 actual %b",
					$time, g, lane_dqs_en[g]);
			end
			if (lane_oct_ena[g] !== '0) begin
				other_errors++;
				$display("[ERROR] t=%0t lane_oct_ena[%0d] expected 00 actual %b",
					$time, g, lane_oct_ena[g]);
			end
		end
		if (afi_rdata_valid !== '0) begin
			other_errors++;
			$display("[ERROR] t=%0t afi_rdata_valid expected 00 actual %b",
				$time, afi_rdata_valid);
		end
	endtask

	// Checks the last cycle's outputs, then drives and records the next inputs
	task automatic advance(input logic rd_en, input logic [groups-1:0] inc, input logic frst);
		logic [31:0] rnd;
		@(negedge pll_afi_clk);
		check_write();
		check_read();
		rnd = $random(seed);
		phy_ddio_dq[slots*groups-1:slots*groups/2] = rnd;
		rnd = $random(seed);
		phy_ddio_dq[slots*groups/2-1:0] = rnd;
		rnd = $random(seed);
		phy_ddio_wrdata_mask = afi_dm_t'(rnd);
		phy_ddio_wrdata_en = afi_half_t'(rnd >> 8);
		// Strobe stays on wherever data is driven
		phy_ddio_dqs_en = afi_half_t'(rnd >> 12) | phy_ddio_wrdata_en;
		phy_ddio_oct_ena = afi_half_t'(rnd >> 16);
		afi_rdata_en = rd_en ? '1 : '0;
		afi_rdata_en_full = rd_en ? '1 : '0;
		seq_read_increment_vfifo_fr = inc;
		seq_read_fifo_reset = frst;
		seq_read_latency_counter = lat;
		dq_h[cyc] = phy_ddio_dq;
		dm_h[cyc] = phy_ddio_wrdata_mask;
		wen_h[cyc] = phy_ddio_wrdata_en;
		dqs_h[cyc] = phy_ddio_dqs_en;
		oct_h[cyc] = phy_ddio_oct_ena;
		en_h[cyc] = rd_en;
		full_h[cyc] = rd_en;
		frst_h[cyc] = frst;
		for (int g = 0; g < groups; g++) begin
			if (inc[g]) begin
				lead[g]++;
			end
		end
		cyc++;
	endtask

	task automatic idle(input int count);
		for (int i = 0; i < count; i++) begin
			advance(1'b0, '0, 1'b0);
		end
	endtask

	task automatic pulse_increment(input int group);
		logic [groups-1:0] inc;
		inc = '0;
		inc[group] = 1'b1;
		advance(1'b0, inc, 1'b0);
	endtask

	task automatic run_bursts(input int count, input int max_len, input logic with_resets);
		logic [31:0] rnd;
		logic on;
		logic frst;
		int left;
		left = 0;
		on = 1'b0;
		for (int i = 0; i < count; i++) begin
			rnd = $random(seed);
			// A new burst needs at least one quiet cycle before it
			if (left == 0 && !on && rnd[1:0] == 2'd0) begin
				left = 1 + int'(rnd[7:4]) % max_len;
			end
			frst = with_resets && (rnd[15:12] == 4'd0);
			on = (left > 0);
			advance(on, '0, frst);
			if (left > 0) begin
				left--;
			end
		end
	endtask

	initial begin
		seed = 32'h78f8772f;
		cyc = 0;
		write_errors = 0;
		read_errors = 0;
		other_errors = 0;
		valid_seen = 0;
		killed = 0;
		lat = lat_t'(2 + `DDR_VFIFO_BASE_OFFSET);
		for (int g = 0; g < groups; g++) begin
			lead[g] = `DDR_VFIFO_BASE_OFFSET;
		end
		reset_n_afi_clk = 1'b0;
		phy_ddio_dq = '0;
		phy_ddio_wrdata_mask = '0;
		phy_ddio_wrdata_en = '0;
		phy_ddio_dqs_en = '0;
		phy_ddio_oct_ena = '0;
		afi_rdata_en = '0;
		afi_rdata_en_full = '0;
		seq_read_latency_counter = lat;
		seq_read_increment_vfifo_fr = '0;
		seq_read_fifo_reset = 1'b0;
		repeat (4) @(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		check_reset_state();
		reset_n_afi_clk = 1'b1;

		// Random write traffic with the read side quiet
		idle(500);

		run_bursts(300, 4, 1'b0);
		idle(40);
		if (valid_seen == 0) begin
			other_errors++;
			$display("Aligned read bursts never raised afi_rdata_valid");
		end

		// Group 0 runs one cycle late, so isolated bursts must not line up
		pulse_increment(0);
		idle(40);
		mark = valid_seen;
		run_bursts(200, 1, 1'b0);
		idle(40);
		if (valid_seen != mark) begin
			other_errors++;
			$display("afi_rdata_valid rose while only group 0 had its VFIFO moved");
		end

		lat = lat + 1'b1;
		pulse_increment(1);
		idle(40);
		mark = valid_seen;
		run_bursts(200, 4, 1'b0);
		idle(40);
		if (valid_seen == mark) begin
			other_errors++;
			$display("afi_rdata_valid did not return after both groups and latency moved");
		end

		run_bursts(200, 4, 1'b1);
		idle(40);
		if (killed == 0) begin
			other_errors++;
			$display("No FIFO reset ever caught a read burst in flight");
		end

		$display("Errors: write %0d, read %0d, other %0d",
			write_errors, read_errors, other_errors);
		if (write_errors + read_errors + other_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge pll_afi_clk);
			cycles++;
		end
		$display("Run stopped after %0d cycles without reaching the end of the tests", cycles);
		$display("Errors: write %0d, read %0d, other %0d",
			write_errors, read_errors, other_errors);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* build.f */
+incdir+src
src/ddr_phy_pkg.sv
src/core_periph_delay.sv
src/write_lane.sv
src/read_vfifo.sv
src/read_lfifo.sv
src/read_valid_align.sv
src/ddr_phy_io_top.sv
sim/tb_ddr_phy_io.sv

/* Makefile */
VERILATOR ?= verilator
TOP := tb_ddr_phy_io
FILELIST := build.f
OBJ_DIR := obj_dir
LOG := sim.log
FLAGS := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "No result found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
